// File: design/mpu_pkg.sv
// Shared types and memory map for the data-side MPU subsystem
// Request, response and PMP configuration formats plus FSM encodings
package mpu_pkg;

  ////////////////////
  // Memory map
  ////////////////////

  // Number of programmable PMP regions
  localparam int unsigned PMP_NUM_REGIONS = 4;

  // Single main-memory region, inclusive byte bounds
  localparam logic [31:0] PMA_MEM_BASE  = 32'h0000_0000;
  localparam logic [31:0] PMA_MEM_LIMIT = 32'h0000_03FF;

  // RAM depth, must cover the PMA region exactly
  localparam int unsigned MEM_WORDS  = 256;
  localparam int unsigned MEM_ADDR_W = $clog2(MEM_WORDS);

  // Outstanding transaction counter width
  localparam int unsigned TXN_CNT_W = 2;

  ////////////////////
  // Transfer formats
  ////////////////////

  // Word request, used on both core and bus side
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
  } mem_req_t;

  // Status returned with every response
  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  typedef struct packed {
    logic [31:0] rdata;
    mpu_status_e status;
  } core_resp_t;

  ////////////////////
  // PMP configuration
  ////////////////////

  // Only user and machine mode exist here
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } privlvl_t;

  typedef enum logic [1:0] {
    PMP_OFF   = 2'b00,
    PMP_TOR   = 2'b01,
    PMP_NA4   = 2'b10,
    PMP_NAPOT = 2'b11
  } pmp_mode_e;

  // Same bit order as a pmpcfg byte
  typedef struct packed {
    logic       lock;
    logic [1:0] reserved;
    pmp_mode_e  mode;
    logic       x;
    logic       w;
    logic       r;
  } pmp_cfg_t;

  // Address entries hold byte address bits 33:2
  typedef struct packed {
    pmp_cfg_t [PMP_NUM_REGIONS-1:0]        cfg;
    logic     [PMP_NUM_REGIONS-1:0][31:0]  addr;
  } pmp_csr_t;

  // Fault FSM states
  typedef enum logic [2:0] {
    MPU_IDLE        = 3'd0,
    MPU_RE_ERR_WAIT = 3'd1,
    MPU_WR_ERR_WAIT = 3'd2,
    MPU_RE_ERR_RESP = 3'd3,
    MPU_WR_ERR_RESP = 3'd4
  } mpu_state_e;

endpackage

// File: design/pma_check.sv
// Physical memory attribute check
// Flags accesses outside main memory or not word aligned
`timescale 1ns/1ps

module pma_check (
  input  logic [31:0] addr_i,
  output logic        pma_err_o
);

  import mpu_pkg::*;

  logic [31:0] addr_offset;
  logic        out_of_range;
  logic        misaligned;

  ////////////////////
  // Range check
  ////////////////////

  // Offset from the region base
  // An address below the base wraps to a large value and fails too
  assign addr_offset  = addr_i - PMA_MEM_BASE;
  // Largest legal offset is the region size minus one byte
  assign out_of_range = (addr_offset > (PMA_MEM_LIMIT - PMA_MEM_BASE));

  ////////////////////
  // Alignment check
  ////////////////////

  // Only whole words are supported
  assign misaligned = (addr_i[1:0] != 2'b00);

  // Either condition is a PMA fault
  assign pma_err_o = out_of_range || misaligned;

endmodule

// File: design/pmp_check.sv
// PMP region matching and permission check for data accesses
// Lowest-numbered matching region decides, per RISC-V priority rules
`timescale 1ns/1ps

module pmp_check (
  input  logic [31:0]       addr_i,
  input  logic              we_i,
  input  mpu_pkg::privlvl_t priv_lvl_i,
  input  mpu_pkg::pmp_csr_t csr_pmp_i,
  output logic              pmp_err_o
);

  import mpu_pkg::*;

  logic [31:0]                word_addr;
  logic [PMP_NUM_REGIONS-1:0] region_hit;
  logic                       any_hit;
  pmp_cfg_t                   sel_cfg;

  // PMP addresses are in word units, bits 33:2 of the byte address
  assign word_addr = {2'b00, addr_i[31:2]};

  ////////////////////
  // Region match
  ////////////////////

  always_comb begin : region_match
    logic [31:0] tor_base;
    logic [31:0] napot_mask;
    // Region 0 TOR starts at address zero
    tor_base   = '0;
    napot_mask = '0;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      // Trailing ones of the entry set the ignored low bits
      napot_mask = ~(csr_pmp_i.addr[i] ^ (csr_pmp_i.addr[i] + 32'd1));
      case (csr_pmp_i.cfg[i].mode)
        PMP_TOR: begin
          region_hit[i] = (word_addr >= tor_base) && (word_addr < csr_pmp_i.addr[i]);
        end
        PMP_NA4: begin
          // Exactly one word
          region_hit[i] = (word_addr == csr_pmp_i.addr[i]);
        end
        PMP_NAPOT: begin
          region_hit[i] = ((word_addr & napot_mask) == (csr_pmp_i.addr[i] & napot_mask));
        end
        default: region_hit[i] = 1'b0;
      endcase
      // Next region's TOR bottom is this entry
      tor_base = csr_pmp_i.addr[i];
    end
  end

  ////////////////////
  // Priority select
  ////////////////////

  always_comb begin : region_select
    logic found;
    found   = 1'b0;
    sel_cfg = '0;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      if (!found && region_hit[i]) begin
        found   = 1'b1;
        sel_cfg = csr_pmp_i.cfg[i];
      end
    end
    any_hit = found;
  end

  // Permission decision
  always_comb begin
    if (!any_hit) begin
      // No match: only M-mode passes
      pmp_err_o = (priv_lvl_i != PRIV_M);
    end else if ((priv_lvl_i != PRIV_M) || sel_cfg.lock) begin
      // U-mode always enforced, M-mode only on locked regions
      pmp_err_o = we_i ? !sel_cfg.w : !sel_cfg.r;
    end else begin
      pmp_err_o = 1'b0;
    end
  end

endmodule

// File: design/txn_tracker.sv
// Outstanding transaction tracker on the core side
// Predicts when exactly one transaction will remain pending
`timescale 1ns/1ps

module txn_tracker (
  input  logic clk,
  input  logic rst_n,
  input  logic req_fire_i,
  input  logic resp_fire_i,
  output logic one_pend_next_o
);

  import mpu_pkg::*;

  logic [TXN_CNT_W-1:0] cnt_q;
  logic [TXN_CNT_W-1:0] cnt_n;

  // Next count, request and response in the same cycle cancel out
  always_comb begin
    cnt_n = cnt_q;
    case ({req_fire_i, resp_fire_i})
      2'b10:   cnt_n = cnt_q + 1'b1;
      2'b01:   cnt_n = cnt_q - 1'b1;
      default: cnt_n = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_n;
    end
  end

  // Seen by the MPU in the same cycle
  assign one_pend_next_o = (cnt_n == TXN_CNT_W'(1));

endmodule

// File: design/mpu.sv
// Data-side memory protection unit
// Gates requests through PMA and PMP checks and returns faults in order
`timescale 1ns/1ps

module mpu (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               core_req_valid_i,
  output logic               core_req_ready_o,
  input  mpu_pkg::mem_req_t  core_req_i,
  output logic               core_resp_valid_o,
  output mpu_pkg::core_resp_t core_resp_o,
  output logic               bus_req_valid_o,
  input  logic               bus_req_ready_i,
  output mpu_pkg::mem_req_t  bus_req_o,
  input  logic               bus_resp_valid_i,
  input  logic [31:0]        bus_rdata_i,
  input  mpu_pkg::pmp_csr_t  csr_pmp_i,
  input  mpu_pkg::privlvl_t  priv_lvl_i,
  input  logic               one_pend_next_i
);

  import mpu_pkg::*;

  logic        pma_err;
  logic        pmp_err;
  logic        mpu_err;
  logic        block_core;
  logic        block_bus;
  logic        err_resp_valid;
  logic        err_req_ready;
  mpu_status_e err_status;
  mpu_state_e  state_q;
  mpu_state_e  state_n;

  ////////////////////
  // Checkers
  ////////////////////

  pma_check u_pma (
    .addr_i    (core_req_i.addr),
    .pma_err_o (pma_err)
  );

  pmp_check u_pmp (
    .addr_i     (core_req_i.addr),
    .we_i       (core_req_i.we),
    .priv_lvl_i (priv_lvl_i),
    .csr_pmp_i  (csr_pmp_i),
    .pmp_err_o  (pmp_err)
  );

  assign mpu_err = pma_err || pmp_err;

  ////////////////////
  // Fault FSM
  ////////////////////

  always_comb begin
    state_n        = state_q;
    block_core     = 1'b0;
    block_bus      = 1'b0;
    err_resp_valid = 1'b0;
    err_req_ready  = 1'b0;
    err_status     = MPU_OK;
    case (state_q)
      MPU_IDLE: begin
        if (core_req_valid_i && mpu_err) begin
          // Take the request but keep it off the bus
          block_bus     = 1'b1;
          err_req_ready = 1'b1;
          if (core_req_i.we) begin
            state_n = one_pend_next_i ? MPU_WR_ERR_RESP : MPU_WR_ERR_WAIT;
          end else begin
            state_n = one_pend_next_i ? MPU_RE_ERR_RESP : MPU_RE_ERR_WAIT;
          end
        end
      end
      MPU_RE_ERR_WAIT, MPU_WR_ERR_WAIT: begin
        // Older responses still draining
        block_core = 1'b1;
        block_bus  = 1'b1;
        if (one_pend_next_i) begin
          state_n = (state_q == MPU_RE_ERR_WAIT) ? MPU_RE_ERR_RESP : MPU_WR_ERR_RESP;
        end
      end
      MPU_RE_ERR_RESP, MPU_WR_ERR_RESP: begin
        block_core     = 1'b1;
        block_bus      = 1'b1;
        err_resp_valid = 1'b1;
        err_status     = (state_q == MPU_RE_ERR_RESP) ? MPU_RE_FAULT : MPU_WR_FAULT;
        // Core never stalls responses
        state_n        = MPU_IDLE;
      end
      default: state_n = MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MPU_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  // Passing requests go out unchanged
  assign bus_req_valid_o  = core_req_valid_i && !block_bus;
  assign bus_req_o        = core_req_i;
  assign core_req_ready_o = (bus_req_ready_i && !block_core) || err_req_ready;

  // Bus data is stale during a fault response, so return zero
  assign core_resp_valid_o  = bus_resp_valid_i || err_resp_valid;
  assign core_resp_o.rdata  = err_resp_valid ? 32'd0 : bus_rdata_i;
  assign core_resp_o.status = err_status;

endmodule

// File: design/mem_target.sv
// Pipelined word RAM target on the bus side
// Two response stages, so data returns two edges after acceptance
`timescale 1ns/1ps

module mem_target (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  mpu_pkg::mem_req_t req_i,
  output logic              resp_valid_o,
  output logic [31:0]       resp_rdata_o
);

  import mpu_pkg::*;

  logic [31:0]           mem_q [MEM_WORDS];
  logic [MEM_ADDR_W-1:0] word_idx;
  logic                  req_fire;
  logic                  s1_valid_q;
  logic                  s2_valid_q;
  logic [31:0]           s1_rdata_q;
  logic [31:0]           s2_rdata_q;

  // One request per cycle, the pipeline never stalls
  assign req_ready_o = 1'b1;
  assign req_fire    = req_valid_i && req_ready_o;

  // Word index, bits 9:2 for 256 words
  assign word_idx = req_i.addr[MEM_ADDR_W+1:2];

  // Write on the accepting edge
  always_ff @(posedge clk) begin
    if (req_fire && req_i.we) begin
      mem_q[word_idx] <= req_i.wdata;
    end
  end

  ////////////////////
  // Response pipeline
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= req_fire;
      s2_valid_q <= s1_valid_q;
    end
  end

  // Read data captured in stage one, writes answer zero
  always_ff @(posedge clk) begin
    if (req_fire) begin
      s1_rdata_q <= req_i.we ? 32'd0 : mem_q[word_idx];
    end
    s2_rdata_q <= s1_rdata_q;
  end

  assign resp_valid_o = s2_valid_q;
  assign resp_rdata_o = s2_rdata_q;

endmodule

// File: design/mpu_subsys_top.sv
// Data-side protection subsystem top
// Tracker, MPU and RAM target between the core ports
`timescale 1ns/1ps

module mpu_subsys_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                core_req_valid_i,
  output logic                core_req_ready_o,
  input  mpu_pkg::mem_req_t   core_req_i,
  output logic                core_resp_valid_o,
  output mpu_pkg::core_resp_t core_resp_o,
  input  mpu_pkg::pmp_csr_t   csr_pmp_i,
  input  mpu_pkg::privlvl_t   priv_lvl_i
);

  import mpu_pkg::*;

  // MPU to RAM
  logic        bus_req_valid;
  logic        bus_req_ready;
  mem_req_t    bus_req;
  logic        bus_resp_valid;
  logic [31:0] bus_rdata;

  // Core-side handshake events seen by the tracker
  logic        req_fire;
  logic        resp_fire;
  logic        one_pend_next;

  assign req_fire  = core_req_valid_i && core_req_ready_o;
  assign resp_fire = core_resp_valid_o;

  txn_tracker u_tracker (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_fire_i      (req_fire),
    .resp_fire_i     (resp_fire),
    .one_pend_next_o (one_pend_next)
  );

  mpu u_mpu (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_valid_i  (core_req_valid_i),
    .core_req_ready_o  (core_req_ready_o),
    .core_req_i        (core_req_i),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_o       (core_resp_o),
    .bus_req_valid_o   (bus_req_valid),
    .bus_req_ready_i   (bus_req_ready),
    .bus_req_o         (bus_req),
    .bus_resp_valid_i  (bus_resp_valid),
    .bus_rdata_i       (bus_rdata),
    .csr_pmp_i         (csr_pmp_i),
    .priv_lvl_i        (priv_lvl_i),
    .one_pend_next_i   (one_pend_next)
  );

  mem_target u_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (bus_req_valid),
    .req_ready_o  (bus_req_ready),
    .req_i        (bus_req),
    .resp_valid_o (bus_resp_valid),
    .resp_rdata_o (bus_rdata)
  );

endmodule

// File: tb/tb_checker.sv
// Scoreboard for the MPU subsystem
// Reference PMA, PMP and RAM model, checks core responses and the ready line
`timescale 1ns/1ps

module tb_checker (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                core_req_valid_i,
  input  logic                core_req_ready_i,
  input  mpu_pkg::mem_req_t   core_req_i,
  input  logic                core_resp_valid_i,
  input  mpu_pkg::core_resp_t core_resp_i,
  input  mpu_pkg::pmp_csr_t   csr_pmp_i,
  input  mpu_pkg::privlvl_t   priv_lvl_i,
  input  logic [8*16-1:0]     test_name_i,
  output logic                idle_o,
  output int                  err_cnt_o,
  output int                  chk_cnt_o
);

  import mpu_pkg::*;

  // One expected response and the rule for when it must arrive
  typedef struct packed {
    core_resp_t  resp;
    logic        fault;
    logic        after_prev;
    logic [31:0] due;
  } exp_t;

  exp_t        exp_q [$];
  logic [31:0] mem_model [MEM_WORDS];
  logic [31:0] cyc = '0;
  logic [31:0] last_resp = '0;
  logic        fault_pend = 1'b0;
  int          errs = 0;
  int          checks = 0;

  assign err_cnt_o = errs;
  assign chk_cnt_o = checks;

  task automatic report_value(input string what, input logic [33:0] exp_v,
                              input logic [33:0] act_v);
    errs++;
    $display("ERROR [%0s] %0s: expected %h, actual %h", test_name_i, what, exp_v, act_v);
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Whether PMP entry idx covers a byte address, worked in 34-bit byte space
  function automatic logic region_covers(pmp_csr_t csr, int idx, logic [31:0] addr);
    logic [33:0] a;
    logic [33:0] lo;
    logic [33:0] hi;
    int          ones;
    a    = {2'b00, addr};
    hi   = {csr.addr[idx], 2'b00};
    lo   = '0;
    ones = 0;
    if (idx > 0) begin
      lo = {csr.addr[idx-1], 2'b00};
    end
    // NAPOT size is 2^(ones+1) words
    while (ones < 32 && csr.addr[idx][ones]) begin
      ones++;
    end
    case (csr.cfg[idx].mode)
      PMP_TOR:   return (a >= lo) && (a < hi);
      PMP_NA4:   return a[33:2] == csr.addr[idx];
      PMP_NAPOT: return (a[33:2] >> (ones + 1)) == (csr.addr[idx] >> (ones + 1));
      default:   return 1'b0;
    endcase
  endfunction

  function automatic logic access_fault(mem_req_t req, privlvl_t priv, pmp_csr_t csr);
    logic in_mem;
    in_mem = (req.addr >= PMA_MEM_BASE) && (req.addr <= PMA_MEM_LIMIT) &&
             (req.addr[1:0] == 2'b00);
    if (!in_mem) begin
      return 1'b1;
    end
    // First matching entry decides
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      if (region_covers(csr, i, req.addr)) begin
        if (priv == PRIV_M && !csr.cfg[i].lock) begin
          return 1'b0;
        end
        return req.we ? !csr.cfg[i].w : !csr.cfg[i].r;
      end
    end
    return priv != PRIV_M;
  endfunction

  ////////////////////
  // Port monitor
  ////////////////////

  always @(posedge clk) begin : monitor
    exp_t        head;
    exp_t        ent;
    logic [31:0] exp_cyc;
    cyc = cyc + 1;
    // Ready drops only while a fault is in flight
    if (core_req_ready_i !== !fault_pend) begin
      report_value("core_req_ready", !fault_pend, core_req_ready_i);
    end
    if (!rst_n) begin
      if (core_resp_valid_i !== 1'b0) begin
        report_value("core_resp_valid in reset", 1'b0, core_resp_valid_i);
      end
      exp_q.delete();
      fault_pend = 1'b0;
    end else begin
      if (core_resp_valid_i === 1'b1) begin
        if (exp_q.size() == 0) begin
          errs++;
          $display("ERROR [%0s] response arrived with no request outstanding", test_name_i);
        end else begin
          head = exp_q.pop_front();
          checks++;
          if (core_resp_i !== head.resp) begin
            report_value("core_resp", head.resp, core_resp_i);
          end
          exp_cyc = head.after_prev ? last_resp + 1 : head.due;
          if (cyc != exp_cyc) begin
            errs++;
            $display("ERROR [%0s] response cycle: expected %0d, actual %0d",
                     test_name_i, exp_cyc, cyc);
          end
          last_resp = cyc;
          if (head.fault) begin
            fault_pend = 1'b0;
          end
        end
      end
      if (core_req_valid_i && core_req_ready_i) begin
        ent = '0;
        if (access_fault(core_req_i, priv_lvl_i, csr_pmp_i)) begin
          // Memory untouched, answer follows any older response
          ent.resp.status = core_req_i.we ? MPU_WR_FAULT : MPU_RE_FAULT;
          ent.fault       = 1'b1;
          ent.after_prev  = (exp_q.size() != 0);
          ent.due         = cyc + 1;
          fault_pend      = 1'b1;
        end else begin
          ent.resp.status = MPU_OK;
          ent.due         = cyc + 2;
          if (core_req_i.we) begin
            mem_model[core_req_i.addr[MEM_ADDR_W+1:2]] = core_req_i.wdata;
          end else begin
            ent.resp.rdata = mem_model[core_req_i.addr[MEM_ADDR_W+1:2]];
          end
        end
        exp_q.push_back(ent);
      end
    end
    idle_o = (exp_q.size() == 0);
  end

endmodule

// File: tb/tb_top.sv
// Testbench top for the MPU subsystem
// Clock, reset, xorshift stimulus, test sequence and watchdog
`timescale 1ns/1ps

module tb_top;

  import mpu_pkg::*;

  // Transactions per test, these also size the watchdog
  localparam int N_FILL  = MEM_WORDS;
  localparam int N_RAND  = 200;
  localparam int N_PMA   = 60;
  localparam int N_UMODE = 80;
  localparam int N_MLOCK = 80;
  localparam int N_ORDER = 12;
  localparam int N_TOTAL = N_FILL + N_RAND + 2 * N_PMA + N_UMODE + N_MLOCK + 4 * N_ORDER;
  localparam int WATCHDOG_CYCLES = N_TOTAL * 8 + 200;

  logic            clk;
  logic            rst_n;
  logic            req_valid;
  logic            req_ready;
  mem_req_t        req;
  logic            resp_valid;
  core_resp_t      resp;
  pmp_csr_t        csr_pmp;
  privlvl_t        priv_lvl;
  logic [8*16-1:0] test_name;
  logic            chk_idle;
  int              chk_errs;
  int              chk_count;
  logic [31:0]     rng_state;
  int              n_txn;
  int              n_tests;
  int              err_base;
  int              txn_base;

  mpu_subsys_top uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_valid_i  (req_valid),
    .core_req_ready_o  (req_ready),
    .core_req_i        (req),
    .core_resp_valid_o (resp_valid),
    .core_resp_o       (resp),
    .csr_pmp_i         (csr_pmp),
    .priv_lvl_i        (priv_lvl)
  );

  tb_checker chk (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_valid_i  (req_valid),
    .core_req_ready_i  (req_ready),
    .core_req_i        (req),
    .core_resp_valid_i (resp_valid),
    .core_resp_i       (resp),
    .csr_pmp_i         (csr_pmp),
    .priv_lvl_i        (priv_lvl),
    .test_name_i       (test_name),
    .idle_o            (chk_idle),
    .err_cnt_o         (chk_errs),
    .chk_cnt_o         (chk_count)
  );

  // 40 ns period
  always #20 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // Aligned word inside main memory
  function automatic logic [31:0] mem_addr(input logic [31:0] r);
    return PMA_MEM_BASE + {22'd0, r[7:0], 2'b00};
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B9) ^ 32'h3C6E_F372;
  endfunction

  // Drive on the falling edge, hold until a rising edge sees ready
  task automatic send_req(input logic [31:0] addr, input logic we, input logic [31:0] wdata);
    @(negedge clk);
    req_valid = 1'b1;
    req.addr  = addr;
    req.we    = we;
    req.wdata = wdata;
    @(posedge clk);
    while (!req_ready) @(posedge clk);
    n_txn++;
  endtask

  task automatic idle_gap(input int n);
    repeat (n) begin
      @(negedge clk);
      req_valid = 1'b0;
    end
  endtask

  task automatic start_test(input logic [8*16-1:0] name);
    test_name = name;
    err_base  = chk_errs;
    txn_base  = n_txn;
  endtask

  // Drain all responses, then report this test
  task automatic finish_test();
    @(negedge clk);
    req_valid = 1'b0;
    while (!chk_idle) @(negedge clk);
    n_tests++;
    $display("Test %0s done: %0d transactions, %0d errors",
             test_name, n_txn - txn_base, chk_errs - err_base);
  endtask

  task automatic set_region(input int idx, input pmp_mode_e mode, input logic lock,
                            input logic w, input logic r, input logic [31:0] addr);
    csr_pmp.cfg[idx].lock     = lock;
    csr_pmp.cfg[idx].reserved = 2'b00;
    csr_pmp.cfg[idx].mode     = mode;
    csr_pmp.cfg[idx].x        = 1'b0;
    csr_pmp.cfg[idx].w        = w;
    csr_pmp.cfg[idx].r        = r;
    csr_pmp.addr[idx]         = addr;
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin : main
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] d;
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    csr_pmp   = '0;
    priv_lvl  = PRIV_M;
    rng_state = 32'h917b;
    n_txn     = 0;
    n_tests   = 0;
    start_test("reset");
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    idle_gap(6);
    finish_test();

    // Fill every word, then random traffic with PMP off
    start_test("mem_traffic");
    for (int i = 0; i < N_FILL; i++) begin
      a = PMA_MEM_BASE + 32'(i) * 32'd4;
      send_req(a, 1'b1, fill_word(a));
    end
    for (int i = 0; i < N_RAND; i++) begin
      r = rand_word();
      a = mem_addr(rand_word());
      d = rand_word();
      send_req(a, r[0], d);
      idle_gap(r[3] ? int'(r[5:4]) : 0);
    end
    finish_test();

    // Misaligned or outside the region, then read the word back
    start_test("pma_faults");
    for (int i = 0; i < N_PMA; i++) begin
      r = rand_word();
      a = mem_addr(rand_word());
      d = rand_word();
      case (r[1:0])
        2'd0:    a = {a[31:2], r[3:2] | 2'b01};
        2'd1:    a = a + 32'h400;
        2'd2:    a = {1'b1, r[30:2], 2'b00};
        default: a = a;
      endcase
      send_req(a, r[4], d);
      send_req(mem_addr({24'd0, a[9:2]}), 1'b0, 32'd0);
    end
    finish_test();

    // RW below 0x100, NA4 read-only, NAPOT write-only, TOR read-only, rest unmatched
    start_test("pmp_umode");
    priv_lvl = PRIV_U;
    set_region(0, PMP_TOR, 1'b0, 1'b1, 1'b1, 32'h0000_0040);
    set_region(1, PMP_NA4, 1'b0, 1'b0, 1'b1, 32'h0000_0040);
    set_region(2, PMP_NAPOT, 1'b0, 1'b1, 1'b0, 32'h0000_0087);
    set_region(3, PMP_TOR, 1'b0, 1'b0, 1'b1, 32'h0000_00C0);
    for (int i = 0; i < N_UMODE; i++) begin
      r = rand_word();
      a = (r[1:0] == 2'd0) ? 32'h0000_0100 : mem_addr(rand_word());
      d = rand_word();
      send_req(a, r[2], d);
      idle_gap(int'(r[4:3] == 2'd3));
    end
    finish_test();

    // Locked read-only below 0x100 ahead of an unlocked overlap, two locked NA4 words
    start_test("pmp_mlock");
    priv_lvl = PRIV_M;
    set_region(0, PMP_NAPOT, 1'b1, 1'b0, 1'b1, 32'h0000_001F);
    set_region(1, PMP_NAPOT, 1'b0, 1'b0, 1'b0, 32'h0000_003F);
    set_region(2, PMP_NA4, 1'b1, 1'b1, 1'b1, 32'h0000_00C0);
    set_region(3, PMP_NA4, 1'b1, 1'b0, 1'b0, 32'h0000_00C1);
    for (int i = 0; i < N_MLOCK; i++) begin
      r = rand_word();
      a = mem_addr(rand_word());
      if (r[1:0] == 2'd0) begin
        a = r[2] ? 32'h0000_0304 : 32'h0000_0300;
      end
      d = rand_word();
      send_req(a, r[3], d);
    end
    finish_test();

    // Two reads, a fault right behind them, then a read held off by the fault
    start_test("fault_order");
    csr_pmp = '0;
    for (int i = 0; i < N_ORDER; i++) begin
      r = rand_word();
      send_req(mem_addr(rand_word()), 1'b0, 32'd0);
      send_req(mem_addr(rand_word()), 1'b0, 32'd0);
      send_req(32'h400 | {22'd0, r[7:0], 2'b00}, r[8], rand_word());
      send_req(mem_addr(rand_word()), 1'b0, 32'd0);
      idle_gap(int'(r[10:9]));
    end
    finish_test();

    $display("Summary: %0d tests, %0d transactions, %0d checks, %0d errors",
             n_tests, n_txn, chk_count, chk_errs);
    if (chk_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Ends a stuck run
  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: compile.f
design/mpu_pkg.sv
design/pma_check.sv
design/pmp_check.sv
design/txn_tracker.sv
design/mpu.sv
design/mem_target.sv
design/mpu_subsys_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
# Builds the MPU subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_top \
  -f compile.f \
  -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

# The run passes only if the pass line is in the log
if grep -qx "All checks passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
